//--- sim.f
cpu_pkg.sv
alu.sv
gr_file.sv
inst_rom.sv
mem_file.sv
cpu_ctrl.sv
mother_board.sv
tb_top.sv

//--- Bender.yml
package:
  name: mother_board

sources:
  - cpu_pkg.sv
  - alu.sv
  - gr_file.sv
  - inst_rom.sv
  - mem_file.sv
  - cpu_ctrl.sv
  - mother_board.sv
  - target: simulation
    files:
      - tb_top.sv

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

  localparam int imem_depth_c = 64;
  localparam int dmem_depth_c = 64;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              run;
  logic              prog_we;
  logic [xlen_c-1:0] prog_addr;
  logic [xlen_c-1:0] prog_data;
  logic              halted;
  store_evt_t        store_evt;

  logic [31:0] prog[$];      // program words, index is the word address
  logic [31:0] exp_addr[$];  // stores predicted by the model
  logic [31:0] exp_data[$];
  logic [31:0] got_addr[$];  // stores seen on the store bus
  logic [31:0] got_data[$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          tests;
  int          cycles;
  int          cycle_limit;  // grows by each program's budget
  int          late_stores;  // stores seen while halted

  mother_board #(.IMEM_DEPTH(imem_depth_c), .DMEM_DEPTH(dmem_depth_c)) dut_i (
    .clk, .arst_n, .run, .prog_we, .prog_addr, .prog_data, .halted, .store_evt
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: halted never rose within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // values here were settled since the falling edge
  always @(posedge clk) begin
    if (arst_n && store_evt.valid === 1'b1) begin
      got_addr.push_back(store_evt.addr);
      got_data.push_back(store_evt.data);
      if (halted !== 1'b0) late_stores++;
    end
  end

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};  // high half is the better half
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic emit(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs1,
                      input logic [3:0] rs2, input logic [3:0] opt, input logic [11:0] imm);
    prog.push_back({imm, rs2, rs1, rd, opt, op});  // imm high, opcode low
  endtask

  // ISA interpreter, all state starts at zero like after reset
  task automatic build_expected();
    logic [31:0] regs [16];
    logic [31:0] dmem [dmem_depth_c];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    int          pc;
    int          next;
    int          steps;
    exp_addr.delete();
    exp_data.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (dmem[i]) dmem[i] = '0;
    pc = 0;
    steps = 0;
    while (steps < prog.size() * 4) begin
      w    = (pc < prog.size()) ? prog[pc] : 32'h0;
      a    = regs[w[15:12]];                     // regs[0] stays zero
      b    = regs[w[19:16]];
      ea   = a + {{20{w[31]}}, w[31:20]};        // rs1 plus sign extended imm
      next = pc + 1;
      steps++;
      if (w[3:0] == op_halt) break;
      case (w[3:0])
        op_addi: res = ea;
        op_alu: begin
          case (w[7:4])
            4'd1:    res = a - b;
            4'd2:    res = a & b;
            4'd3:    res = a | b;
            4'd4:    res = a ^ b;
            default: res = a + b;  // programs only use 0 to 4
          endcase
        end
        op_jalr: begin
          res  = pc + 1;  // link
          next = a;       // target read before the link lands
        end
        op_jeq:  next = (b == 0) ? a : pc + 1;
        op_lw:   res = dmem[ea % dmem_depth_c];
        op_sw: begin
          dmem[ea % dmem_depth_c] = b;
          exp_addr.push_back(ea % dmem_depth_c);
          exp_data.push_back(b);
        end
        default: ;  // nop
      endcase
      if (w[3:0] inside {op_addi, op_alu, op_jalr, op_lw} && w[11:8] != 0) begin
        regs[w[11:8]] = res;
      end
      pc = next;
    end
  endtask

  task automatic run_program(input string name, input int extra);
    int errs_before;
    int i;
    errs_before = errors;
    build_expected();
    cycle_limit += prog.size() * 4 + 5 + prog.size() + extra + 8;  // run, reset, load
    @(negedge clk);
    arst_n  = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    got_addr.delete();
    got_data.delete();
    late_stores = 0;
    foreach (prog[k]) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = k;
      prog_data = prog[k];
    end
    @(negedge clk);
    prog_we = 1'b0;
    run     = 1'b1;
    while (halted !== 1'b1) @(negedge clk);
    repeat (extra) @(negedge clk);  // run stays high past the halt
    run = 1'b0;
    check_value({name, " store count"}, exp_addr.size(), got_addr.size());
    for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check_value($sformatf("%s store %0d addr", name, i), exp_addr[i], got_addr[i]);
      check_value($sformatf("%s store %0d data", name, i), exp_data[i], got_data[i]);
    end
    check_value({name, " stores after halt"}, 0, late_stores);
    tests++;
    $display("test %s done, %0d stores, %0d errors", name, got_addr.size(),
             errors - errs_before);
  endtask

  initial begin
    logic [3:0] rd;
    arst_n      = 1'b0;
    run         = 1'b0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    lcg_state   = 32'd95;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    cycles      = 0;
    cycle_limit = 0;
    late_stores = 0;

    prog.delete();  // chain through every register, then dump them
    for (int r = 1; r < reg_cnt_c; r++) emit(op_addi, r, r - 1, 0, 0, rand_word());
    for (int r = 1; r < reg_cnt_c; r++) emit(op_sw, 0, 0, r, 0, r);
    emit(op_halt, 0, 0, 0, 0, 0);
    run_program("addi_chain", 0);

    prog.delete();
    for (int r = 1; r <= 8; r++) emit(op_addi, r, 0, 0, 0, rand_word());
    for (int k = 0; k < 10; k++) begin
      rd = 9 + k % 7;
      emit(op_alu, rd, 1 + rand_word() % 15, 1 + rand_word() % 15, k % 5, 0);
      emit(op_sw, 0, 0, rd, 0, 16 + k);
    end
    emit(op_halt, 0, 0, 0, 0, 0);
    run_program("alu_mix", 0);

    prog.delete();
    for (int k = 0; k < 4; k++) begin
      rd = rand_word();                                // reused as a spare nibble
      emit(op_addi, 1, 0, 0, 0, rand_word());          // base
      emit(op_addi, 2, 0, 0, 0, rand_word());          // data
      emit(op_sw, 0, 1, 2, 0, {rd, 8'h35} ^ k);        // offset, may be negative
      emit(op_lw, 3, 1, 0, 0, {rd, 8'h35} ^ k);
      emit(op_sw, 0, 0, 3, 0, 40 + k);                 // re-store the loaded copy
    end
    emit(op_halt, 0, 0, 0, 0, 0);
    run_program("load_store", 0);

    prog.delete();
    emit(op_addi, 1, 0, 0, 0, 6);                      // jump target
    emit(op_jalr, 2, 1, 0, 0, 0);
    repeat (4) emit(op_halt, 0, 0, 0, 0, 0);           // skipped block
    emit(op_addi, 3, 0, 0, 0, rand_word());            // marker
    emit(op_sw, 0, 0, 2, 0, 1);                        // link, expect 2
    emit(op_sw, 0, 0, 3, 0, 2);
    emit(op_halt, 0, 0, 0, 0, 0);
    run_program("jalr_skip", 0);

    prog.delete();
    emit(op_addi, 1, 0, 0, 0, 4);
    emit(op_jeq, 0, 1, 0, 0, 0);                       // x0 is zero so taken
    emit(op_halt, 0, 0, 0, 0, 0);
    emit(op_halt, 0, 0, 0, 0, 0);
    emit(op_addi, 2, 0, 0, 0, rand_word());
    emit(op_sw, 0, 0, 2, 0, 3);                        // marker that must appear
    emit(op_addi, 4, 0, 0, 0, (rand_word() & 32'h3ff) | 32'h1);
    emit(op_addi, 5, 0, 0, 0, 11);
    emit(op_jeq, 0, 5, 4, 0, 0);                       // x4 nonzero so falls through
    emit(op_halt, 0, 0, 0, 0, 0);
    emit(op_halt, 0, 0, 0, 0, 0);
    emit(op_addi, 6, 0, 0, 0, rand_word());
    emit(op_sw, 0, 0, 6, 0, 4);                        // marker that must not appear
    emit(op_halt, 0, 0, 0, 0, 0);
    run_program("jeq_both", 0);

    prog.delete();
    emit(op_addi, 0, 0, 0, 0, (rand_word() & 32'h7ff) | 32'h1);
    emit(op_sw, 0, 0, 0, 0, 5);                        // x0 still reads zero
    emit(op_halt, 0, 0, 0, 0, 0);
    emit(op_sw, 0, 0, 0, 0, 6);                        // only reached if halt leaks
    run_program("x0_idle", 20);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- mother_board.sv
`timescale 1ns/1ps

module mother_board import cpu_pkg::*; #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,
  input  logic              prog_we,
  input  logic [xlen_c-1:0] prog_addr,
  input  logic [xlen_c-1:0] prog_data,
  output logic              halted,
  output store_evt_t        store_evt
);

  logic [$clog2(IMEM_DEPTH)-1:0] pc;
  instr_t                        instr;
  ctrl_t                         ctrl;
  logic [xlen_c-1:0]             rs1_val;     // base, jump target
  logic [xlen_c-1:0]             rs2_val;     // operand, store data
  logic [xlen_c-1:0]             alu_result;  // also the data address
  logic                          rs2_zero;
  logic [xlen_c-1:0]             mem_rdata;
  logic                          wr_en;
  logic [reg_aw_c-1:0]           wr_addr;
  logic [xlen_c-1:0]             wr_data;

  cpu_ctrl #(.IMEM_DEPTH(IMEM_DEPTH)) cpu_ctrl (
    .clk, .arst_n, .run, .instr, .alu_result, .rs2_zero, .rs1_val,
    .mem_rdata, .pc, .ctrl, .wr_en, .wr_addr, .wr_data, .halted
  );

  inst_rom #(.IMEM_DEPTH(IMEM_DEPTH)) inst_rom (
    .clk, .prog_we, .prog_addr, .prog_data, .pc, .instr
  );

  gr_file gr_file (
    .clk, .arst_n,
    .rs1     (instr.rs1),
    .rs2     (instr.rs2),
    .rs1_val, .rs2_val, .wr_en, .wr_addr, .wr_data
  );

  alu alu (
    .a        (rs1_val),
    .b        (rs2_val),
    .imm      (instr.imm),
    .use_imm  (ctrl.use_imm),
    .alu_op   (ctrl.alu_op),
    .result   (alu_result),
    .rs2_zero
  );

  mem_file #(.DMEM_DEPTH(DMEM_DEPTH)) mem_file (
    .clk, .arst_n,
    .addr   (alu_result),
    .wdata  (rs2_val),
    .mem_we (ctrl.mem_we),
    .rdata  (mem_rdata),
    .store_evt
  );

endmodule

//--- cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl import cpu_pkg::*; #(
  parameter  int IMEM_DEPTH = 64,
  localparam int pc_w       = $clog2(IMEM_DEPTH)
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,         // level, execute while high
  input  instr_t            instr,       // word at pc
  input  logic [xlen_c-1:0] alu_result,
  input  logic              rs2_zero,    // branch condition for jeq
  input  logic [xlen_c-1:0] rs1_val,     // jump target
  input  logic [xlen_c-1:0] mem_rdata,   // load data
  output logic [pc_w-1:0]   pc,          // word address of the fetch
  output ctrl_t             ctrl,
  output logic              wr_en,
  output logic [reg_aw_c-1:0] wr_addr,
  output logic [xlen_c-1:0] wr_data,
  output logic              halted       // sticky until reset
);

  localparam logic [1:0] wb_alu  = 2'd0;  // alu result
  localparam logic [1:0] wb_mem  = 2'd1;  // load data
  localparam logic [1:0] wb_link = 2'd2;  // return address

  logic              exec;     // an instruction retires this cycle
  logic              is_halt;
  logic [xlen_c-1:0] link;     // pc + 1 as a full word
  logic [xlen_c-1:0] next_pc;  // kept wide so a bad target is visible

  assign exec    = run && !halted;
  assign is_halt = (instr.opcode == op_halt);
  assign link    = xlen_c'(pc) + 1'b1;

  always_comb begin
    ctrl = '0;  // nop, alu_add, no writes
    case (instr.opcode)
      op_addi: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = wb_alu;
      end
      op_alu: begin
        ctrl.alu_op = alu_op_e'(instr.opt);  // opt maps straight onto the op
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_alu;
      end
      op_jalr: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_link;
      end
      op_lw: begin
        ctrl.use_imm = 1'b1;  // address = rs1 + imm
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = wb_mem;
      end
      op_sw: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_we  = 1'b1;
      end
      default: ;  // jeq, halt and nops write nothing
    endcase
    ctrl.reg_we = ctrl.reg_we && exec;  // no side effects while stopped
    ctrl.mem_we = ctrl.mem_we && exec;
  end

  always_comb begin
    case (instr.opcode)
      op_jalr: next_pc = rs1_val;
      op_jeq:  next_pc = rs2_zero ? rs1_val : link;
      op_halt: next_pc = xlen_c'(pc);  // park on the halt
      default: next_pc = link;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wr_data = mem_rdata;
      wb_link: wr_data = link;
      default: wr_data = alu_result;
    endcase
  end

  assign wr_en   = ctrl.reg_we;
  assign wr_addr = instr.rd;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (exec) begin
      pc <= next_pc[pc_w-1:0];
      if (is_halt) begin
        halted <= 1'b1;  // takes effect at the end of the halt cycle
      end
    end
  end

  // jumps and fall-through must stay inside the loaded program
  a_pc_range: assert property (@(posedge clk) disable iff (!arst_n)
    exec |-> (next_pc < IMEM_DEPTH))
    else $error("next pc %0d outside instruction memory", next_pc);

endmodule

//--- mem_file.sv
`timescale 1ns/1ps

module mem_file import cpu_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [xlen_c-1:0] addr,    // alu result, word address
  input  logic [xlen_c-1:0] wdata,   // rs2 value
  input  logic              mem_we,
  output logic [xlen_c-1:0] rdata,
  output store_evt_t        store_evt
);

  localparam int dm_aw = $clog2(DMEM_DEPTH);

  logic [DMEM_DEPTH-1:0][xlen_c-1:0] mem;
  logic [dm_aw-1:0]                  idx;  // address wrapped into the array

  assign idx   = dm_aw'(addr % DMEM_DEPTH);
  assign rdata = mem[idx];  // load data in the same cycle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem <= '0;
    end else if (mem_we) begin
      mem[idx] <= wdata;
    end
  end

  // board store bus, shows the write before its edge
  assign store_evt.valid = mem_we;
  assign store_evt.addr  = xlen_c'(idx);
  assign store_evt.data  = wdata;

  // a pending write carries a known address and word
  a_store_known: assert property (@(posedge clk) disable iff (!arst_n)
    store_evt.valid |-> !$isunknown({store_evt.addr, store_evt.data}))
    else $error("store bus carries an unknown address or data");

endmodule

//--- inst_rom.sv
`timescale 1ns/1ps

module inst_rom import cpu_pkg::*; #(
  parameter  int IMEM_DEPTH = 64,
  localparam int pc_w       = $clog2(IMEM_DEPTH)
) (
  input  logic              clk,
  input  logic              prog_we,    // one strobe per word
  input  logic [xlen_c-1:0] prog_addr,  // word index
  input  logic [xlen_c-1:0] prog_data,
  input  logic [pc_w-1:0]   pc,
  output instr_t            instr
);

  logic [IMEM_DEPTH-1:0][xlen_c-1:0] mem;  // program store, loaded before run

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr[pc_w-1:0]] <= prog_data;
    end
  end

  assign instr = instr_t'(mem[pc]);  // asynchronous fetch

  // a load past the end would alias onto a low word
  a_prog_range: assert property (@(posedge clk)
    prog_we |-> (prog_addr < IMEM_DEPTH))
    else $error("program word %0d beyond instruction memory", prog_addr);

endmodule

//--- gr_file.sv
`timescale 1ns/1ps

module gr_file import cpu_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [reg_aw_c-1:0] rs1,
  input  logic [reg_aw_c-1:0] rs2,
  output logic [xlen_c-1:0]   rs1_val,
  output logic [xlen_c-1:0]   rs2_val,
  input  logic                wr_en,
  input  logic [reg_aw_c-1:0] wr_addr,
  input  logic [xlen_c-1:0]   wr_data
);

  logic [reg_cnt_c-1:0][xlen_c-1:0] x;  // x[0] is never written

  // both ports read through, x0 forced to zero
  assign rs1_val = (rs1 == '0) ? '0 : x[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : x[rs2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x <= '0;
    end else if (wr_en && (wr_addr != '0)) begin  // drop writes to x0
      x[wr_addr] <= wr_data;
    end
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  logic [xlen_c-1:0]  a,         // rs1 value
  input  logic [xlen_c-1:0]  b,         // rs2 value
  input  logic [imm_w_c-1:0] imm,
  input  logic               use_imm,
  input  alu_op_e            alu_op,
  output logic [xlen_c-1:0]  result,
  output logic               rs2_zero
);

  logic [xlen_c-1:0] imm_ext;  // sign extended immediate
  logic [xlen_c-1:0] opb;      // selected second operand

  assign imm_ext = {{(xlen_c-imm_w_c){imm[imm_w_c-1]}}, imm};
  assign opb     = use_imm ? imm_ext : b;

  always_comb begin
    case (alu_op)
      alu_add: result = a + opb;
      alu_sub: result = a - opb;
      alu_and: result = a & opb;
      alu_or:  result = a | opb;
      alu_xor: result = a ^ opb;
      default: result = a + opb;  // unused opt codes fall back to add
    endcase
  end

  assign rs2_zero = (b == '0);  // jeq tests the raw rs2, never the imm

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  localparam int xlen_c    = 32;                 // data path width, one word
  localparam int reg_cnt_c = 16;                 // architectural registers
  localparam int reg_aw_c  = $clog2(reg_cnt_c);  // register index width
  localparam int imm_w_c   = 12;                 // immediate field width

  // major opcode, low nibble of the instruction word
  typedef enum logic [3:0] {
    op_addi = 4'h0,  // rd = rs1 + imm
    op_alu  = 4'h1,  // rd = rs1 op rs2
    op_jalr = 4'h2,  // rd = pc + 1, pc = rs1
    op_jeq  = 4'h3,  // pc = rs1 when rs2 is zero
    op_lw   = 4'h4,  // rd = mem[rs1 + imm]
    op_sw   = 4'h5,  // mem[rs1 + imm] = rs2
    op_halt = 4'hA   // stop until reset
  } opcode_e;

  // alu operation, same code as the opt field
  typedef enum logic [3:0] {
    alu_add = 4'h0,
    alu_sub = 4'h1,
    alu_and = 4'h2,
    alu_or  = 4'h3,
    alu_xor = 4'h4
  } alu_op_e;

  // instruction word, high bits first
  typedef struct packed {
    logic [imm_w_c-1:0]  imm;     // signed offset or constant
    logic [reg_aw_c-1:0] rs2;     // second source, store data
    logic [reg_aw_c-1:0] rs1;     // first source, base or jump target
    logic [reg_aw_c-1:0] rd;      // destination
    logic [3:0]          opt;     // alu function for op_alu
    opcode_e             opcode;  // unknown codes run as nop
  } instr_t;

  // decoded controls for the datapath
  typedef struct packed {
    alu_op_e    alu_op;   // alu function
    logic       use_imm;  // operand b is the sign extended imm
    logic       reg_we;   // register file write
    logic [1:0] wb_sel;   // write-back source
    logic       mem_we;   // data memory write
  } ctrl_t;

  // one data memory write as seen on the board store bus
  typedef struct packed {
    logic              valid;  // a write happens at the coming edge
    logic [xlen_c-1:0] addr;   // word index after wrap
    logic [xlen_c-1:0] data;   // word being written
  } store_evt_t;

endpackage
